// ==== soc_pkg.sv ====
// peripheral subsystem package: bus widths, address map, target and op types
package soc_pkg;

  // --------------------------------------------------------------------
  // bus widths
  // --------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;

  // --------------------------------------------------------------------
  // address map
  // --------------------------------------------------------------------
  localparam logic [AddrWidth-1:0] RomBase     = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] RomLength   = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] ClintBase   = 32'h0200_0000;
  localparam logic [AddrWidth-1:0] ClintLength = 32'h0000_C000;
  localparam logic [AddrWidth-1:0] BoardBase   = 32'h4000_0000;
  localparam logic [AddrWidth-1:0] BoardLength = 32'h0000_1000;

  // clint register offsets
  localparam logic [AddrWidth-1:0] MsipOffset     = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] MtimecmpOffset = 32'h0000_4000;
  localparam logic [AddrWidth-1:0] MtimeOffset    = 32'h0000_BFF8;

  // board register offsets
  localparam logic [AddrWidth-1:0] LedOffset = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] SwOffset  = 32'h0000_0008;

  // --------------------------------------------------------------------
  // types
  // --------------------------------------------------------------------
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

  typedef enum logic [1:0] {
    TGT_ROM   = 2'd0,
    TGT_CLINT = 2'd1,
    TGT_BOARD = 2'd2,
    TGT_NONE  = 2'd3
  } target_e;

  // request as issued by the external master
  typedef struct packed {
    bus_op_e              op;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_rsp_t;

  // decoded request leaving stage 1
  typedef struct packed {
    logic     valid;
    bus_req_t req;
    target_e  target;
  } stage_req_t;

endpackage

// ==== addr_decode.sv ====
// stage 1 registers each request together with its decoded target window
`timescale 1ns/1ns

module addr_decode (
  input  logic                clk,
  input  logic                ndmreset_n,
  input  logic                req_valid_i,
  input  soc_pkg::bus_req_t   req_i,
  output soc_pkg::stage_req_t stage_o,
  output logic                rom_sel_o,
  output logic                clint_sel_o,
  output logic                board_sel_o
);
  import soc_pkg::*;

  target_e  target_d;
  target_e  target_q;
  bus_req_t req_q;
  logic     valid_q;

  // --------------------------------------------------------------------
  // window compare
  // --------------------------------------------------------------------
  always_comb begin
    target_d = TGT_NONE;
    if (req_i.addr >= RomBase && req_i.addr < RomBase + RomLength) begin
      target_d = TGT_ROM;
    end else if (req_i.addr >= ClintBase && req_i.addr < ClintBase + ClintLength) begin
      target_d = TGT_CLINT;
    end else if (req_i.addr >= BoardBase && req_i.addr < BoardBase + BoardLength) begin
      target_d = TGT_BOARD;
    end
  end

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_valid_i;
    end
  end

  // request payload only loads on a strobe
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      req_q    <= req_i;
      target_q <= target_d;
    end
  end

  assign stage_o = '{valid: valid_q, req: req_q, target: target_q};

  // one select per peripheral so nothing downstream decodes base addresses
  assign rom_sel_o   = valid_q && (target_q == TGT_ROM);
  assign clint_sel_o = valid_q && (target_q == TGT_CLINT);
  assign board_sel_o = valid_q && (target_q == TGT_BOARD);

  // all four codes are legal, so an unknown target is the only illegal one
  a_target_legal : assert property (
    @(posedge clk) disable iff (!ndmreset_n)
    valid_q |-> !$isunknown(target_q)
  );

endmodule

// ==== boot_rom.sv ====
// boot rom: fixed pattern table with a registered read and a write error flag
`timescale 1ns/1ns

module boot_rom #(
  parameter int unsigned RomWords = 16
) (
  input  logic                          clk,
  input  logic                          ndmreset_n,
  input  logic                          sel_i,
  input  soc_pkg::bus_req_t             req_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  output logic                          err_o
);
  import soc_pkg::*;

  localparam int unsigned ByteBits = $clog2(DataWidth / 8);
  localparam int unsigned WinBits  = $clog2(RomLength) - ByteBits;
  localparam int unsigned IdxBits  = (RomWords > 1) ? $clog2(RomWords) : 1;

  logic [DataWidth-1:0] rom_mem [RomWords];
  logic [WinBits-1:0]   word_idx;

  // upper half is a tagged index, lower half its inverse
  for (genvar i = 0; i < RomWords; i++) begin : g_rom
    localparam logic [31:0] Upper = 32'hB007_0000 + i;
    assign rom_mem[i] = {Upper, ~Upper};
  end

  assign word_idx = req_i.addr[ByteBits +: WinBits];

  always_ff @(posedge clk) begin
    if (sel_i && req_i.op == OP_READ) begin
      rdata_o <= (word_idx < RomWords) ? rom_mem[word_idx[IdxBits-1:0]] : '0;
    end
  end

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      err_o <= 1'b0;
    end else begin
      err_o <= sel_i && (req_i.op == OP_WRITE);
    end
  end

endmodule

// ==== clint_timer.sv ====
// core-local timer: rtc divider, msip, mtimecmp and mtime with irq outputs
`timescale 1ns/1ns

module clint_timer (
  input  logic                          clk,
  input  logic                          ndmreset_n,
  input  logic                          sel_i,
  input  soc_pkg::bus_req_t             req_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  output logic                          timer_irq_o,
  output logic                          ipi_o
);
  import soc_pkg::*;

  // low address bits cover the whole 0xC000 window
  localparam int unsigned OffBits = 16;

  logic                 rtc_q;
  logic                 msip_q;
  logic [DataWidth-1:0] mtime_q;
  logic [DataWidth-1:0] mtimecmp_q;
  logic [OffBits-1:0]   offset;
  logic                 wr_en;
  logic                 msip_we;
  logic                 mtimecmp_we;
  logic                 mtime_we;

  assign offset      = req_i.addr[OffBits-1:0];
  assign wr_en       = sel_i && (req_i.op == OP_WRITE);
  assign msip_we     = wr_en && (offset == MsipOffset[OffBits-1:0]);
  assign mtimecmp_we = wr_en && (offset == MtimecmpOffset[OffBits-1:0]);
  assign mtime_we    = wr_en && (offset == MtimeOffset[OffBits-1:0]);

  // --------------------------------------------------------------------
  // rtc at half the bus clock
  // --------------------------------------------------------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_q <= 1'b0;
    end else begin
      rtc_q <= ~rtc_q;
    end
  end

  // --------------------------------------------------------------------
  // timer registers
  // --------------------------------------------------------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q     <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      if (msip_we) begin
        msip_q <= req_i.wdata[0];
      end
      if (mtimecmp_we) begin
        mtimecmp_q <= req_i.wdata;
      end
      // a bus write wins over the tick
      if (mtime_we) begin
        mtime_q <= req_i.wdata;
      end else if (rtc_q) begin
        mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  // read mux, unmapped offsets read zero
  always_ff @(posedge clk) begin
    if (sel_i && req_i.op == OP_READ) begin
      if (offset == MsipOffset[OffBits-1:0]) begin
        rdata_o <= {{(DataWidth-1){1'b0}}, msip_q};
      end else if (offset == MtimecmpOffset[OffBits-1:0]) begin
        rdata_o <= mtimecmp_q;
      end else if (offset == MtimeOffset[OffBits-1:0]) begin
        rdata_o <= mtime_q;
      end else begin
        rdata_o <= '0;
      end
    end
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

  // time only moves backwards through an explicit bus write
  a_mtime_monotonic : assert property (
    @(posedge clk) disable iff (!ndmreset_n)
    !mtime_we |=> (mtime_q >= $past(mtime_q))
  );

endmodule

// ==== board_ctrl.sv ====
// board registers: led output, switch readback and fan pwm from switches
`timescale 1ns/1ns

module board_ctrl #(
  parameter int unsigned FanBits = 4
) (
  input  logic                          clk,
  input  logic                          ndmreset_n,
  input  logic                          sel_i,
  input  soc_pkg::bus_req_t             req_i,
  input  logic [7:0]                    sw_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  output logic [7:0]                    led_o,
  output logic                          fan_pwm_o
);
  import soc_pkg::*;

  localparam int unsigned OffBits = $clog2(BoardLength);

  logic [OffBits-1:0] offset;
  logic [FanBits-1:0] pwm_cnt_q;

  assign offset = req_i.addr[OffBits-1:0];

  // --------------------------------------------------------------------
  // bus registers
  // --------------------------------------------------------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      led_o <= '0;
    end else if (sel_i && req_i.op == OP_WRITE && offset == LedOffset[OffBits-1:0]) begin
      led_o <= req_i.wdata[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (sel_i && req_i.op == OP_READ) begin
      if (offset == LedOffset[OffBits-1:0]) begin
        rdata_o <= {{(DataWidth-8){1'b0}}, led_o};
      end else if (offset == SwOffset[OffBits-1:0]) begin
        rdata_o <= {{(DataWidth-8){1'b0}}, sw_i};
      end else begin
        rdata_o <= '0;
      end
    end
  end

  // --------------------------------------------------------------------
  // fan pwm
  // --------------------------------------------------------------------
  // free-running counter, one full period every 2**FanBits clocks
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      pwm_cnt_q <= '0;
      fan_pwm_o <= 1'b0;
    end else begin
      pwm_cnt_q <= pwm_cnt_q + 1'b1;
      fan_pwm_o <= (pwm_cnt_q < sw_i[FanBits-1:0]);
    end
  end

endmodule

// ==== resp_merge.sv ====
// stage 3: aligns the decoded stage with peripheral data and registers the response
`timescale 1ns/1ns

module resp_merge (
  input  logic                          clk,
  input  logic                          ndmreset_n,
  input  soc_pkg::stage_req_t           stage_i,
  input  logic [soc_pkg::DataWidth-1:0] rom_rdata_i,
  input  logic [soc_pkg::DataWidth-1:0] clint_rdata_i,
  input  logic [soc_pkg::DataWidth-1:0] board_rdata_i,
  input  logic                          rom_err_i,
  output logic                          rsp_valid_o,
  output soc_pkg::bus_rsp_t             rsp_o
);
  import soc_pkg::*;

  logic                 valid_q;
  target_e              target_q;
  bus_op_e              op_q;
  logic [DataWidth-1:0] sel_rdata;
  logic                 rsp_err;

  // stage-1 info delayed to line up with the peripheral registers
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q     <= 1'b0;
      target_q    <= TGT_NONE;
      op_q        <= OP_READ;
      rsp_valid_o <= 1'b0;
    end else begin
      valid_q     <= stage_i.valid;
      target_q    <= stage_i.target;
      op_q        <= stage_i.req.op;
      rsp_valid_o <= valid_q;
    end
  end

  always_comb begin
    unique case (target_q)
      TGT_ROM:   sel_rdata = rom_rdata_i;
      TGT_CLINT: sel_rdata = clint_rdata_i;
      TGT_BOARD: sel_rdata = board_rdata_i;
      default:   sel_rdata = '0;
    endcase
    rsp_err = (target_q == TGT_NONE) || (target_q == TGT_ROM && rom_err_i);
  end

  // writes and errors never return data
  always_ff @(posedge clk) begin
    rsp_o.err   <= rsp_err;
    rsp_o.rdata <= (op_q == OP_WRITE || rsp_err) ? '0 : sel_rdata;
  end

  a_rsp_has_req : assert property (
    @(posedge clk) disable iff (!ndmreset_n)
    rsp_valid_o |-> $past(stage_i.valid, 2)
  );

endmodule

// ==== soc_top.sv ====
// peripheral subsystem top: decode, peripheral access and response merge stages
`timescale 1ns/1ns

module soc_top #(
  parameter int unsigned RomWords = 16,
  parameter int unsigned FanBits  = 4
) (
  input  logic              clk,
  input  logic              ndmreset_n,
  input  logic              req_valid_i,
  input  soc_pkg::bus_req_t req_i,
  output logic              rsp_valid_o,
  output soc_pkg::bus_rsp_t rsp_o,
  input  logic [7:0]        sw_i,
  output logic [7:0]        led_o,
  output logic              fan_pwm_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);
  import soc_pkg::*;

  stage_req_t           stage;
  logic                 rom_sel;
  logic                 clint_sel;
  logic                 board_sel;
  logic [DataWidth-1:0] rom_rdata;
  logic [DataWidth-1:0] clint_rdata;
  logic [DataWidth-1:0] board_rdata;
  logic                 rom_err;

  // --------------------------------------------------------------------
  // stage 1
  // --------------------------------------------------------------------
  addr_decode u_addr_decode (
    .clk         ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .stage_o     ( stage       ),
    .rom_sel_o   ( rom_sel     ),
    .clint_sel_o ( clint_sel   ),
    .board_sel_o ( board_sel   )
  );

  // --------------------------------------------------------------------
  // stage 2, peripherals side by side
  // --------------------------------------------------------------------
  boot_rom #(.RomWords(RomWords)) u_boot_rom (
    .clk(clk), .ndmreset_n(ndmreset_n), .sel_i(rom_sel), .req_i(stage.req),
    .rdata_o(rom_rdata), .err_o(rom_err)
  );

  clint_timer u_clint_timer (
    .clk(clk), .ndmreset_n(ndmreset_n), .sel_i(clint_sel), .req_i(stage.req),
    .rdata_o(clint_rdata), .timer_irq_o(timer_irq_o), .ipi_o(ipi_o)
  );

  board_ctrl #(.FanBits(FanBits)) u_board_ctrl (
    .clk(clk), .ndmreset_n(ndmreset_n), .sel_i(board_sel), .req_i(stage.req),
    .sw_i(sw_i), .rdata_o(board_rdata), .led_o(led_o), .fan_pwm_o(fan_pwm_o)
  );

  // --------------------------------------------------------------------
  // stage 3
  // --------------------------------------------------------------------
  resp_merge u_resp_merge (
    .clk(clk), .ndmreset_n(ndmreset_n), .stage_i(stage),
    .rom_rdata_i(rom_rdata), .clint_rdata_i(clint_rdata), .board_rdata_i(board_rdata),
    .rom_err_i(rom_err), .rsp_valid_o(rsp_valid_o), .rsp_o(rsp_o)
  );

endmodule

// ==== tb_soc.sv ====
// testbench for the peripheral subsystem with case file replay and timer, led and fan checks
`timescale 1ns/1ns

module tb_soc;
  import soc_pkg::*;

  localparam int unsigned RspLatency = 3;

  logic       clk;
  logic       ndmreset_n;
  logic       req_valid_i;
  bus_req_t   req_i;
  logic       rsp_valid_o;
  bus_rsp_t   rsp_o;
  logic [7:0] sw_i;
  logic [7:0] led_o;
  logic       fan_pwm_o;
  logic       timer_irq_o;
  logic       ipi_o;

  int unsigned          cycle_cnt;
  int unsigned          issued_cnt;
  int unsigned          done_cnt;
  int unsigned          due_q[$];
  logic [DataWidth-1:0] exp_rdata_q[$];
  logic                 exp_err_q[$];
  bit                   check_q[$];
  logic [DataWidth-1:0] last_rdata;
  int                   seed;

  soc_top #(.RomWords(16), .FanBits(4)) u_dut (
    .clk(clk), .ndmreset_n(ndmreset_n), .req_valid_i(req_valid_i), .req_i(req_i),
    .rsp_valid_o(rsp_valid_o), .rsp_o(rsp_o), .sw_i(sw_i), .led_o(led_o),
    .fan_pwm_o(fan_pwm_o), .timer_irq_o(timer_irq_o), .ipi_o(ipi_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // --------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [DataWidth-1:0] got,
                          input logic [DataWidth-1:0] exp);
    assert (got === exp)
      else fail_now($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic issue_req(input bus_op_e op, input logic [AddrWidth-1:0] addr,
                           input logic [DataWidth-1:0] wdata,
                           input logic [DataWidth-1:0] exp_rdata,
                           input logic exp_err, input bit check);
    @(posedge clk);
    req_valid_i <= 1'b1;
    req_i       <= '{op: op, addr: addr, wdata: wdata};
    // cycle_cnt still holds the count of the previous edge here
    due_q.push_back(cycle_cnt + 1 + RspLatency);
    exp_rdata_q.push_back(exp_rdata);
    exp_err_q.push_back(exp_err);
    check_q.push_back(check);
    issued_cnt++;
  endtask

  task automatic release_bus();
    @(posedge clk);
    req_valid_i <= 1'b0;
  endtask

  task automatic drain_responses(input int unsigned limit);
    int unsigned waited;
    waited = 0;
    while (done_cnt < issued_cnt) begin
      @(posedge clk);
      waited++;
      assert (waited <= limit) else fail_now("timeout while waiting for bus responses");
    end
    @(negedge clk);
  endtask

  // single access that hands back the read data
  task automatic bus_access(input bus_op_e op, input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] wdata,
                            output logic [DataWidth-1:0] rdata);
    issue_req(op, addr, wdata, '0, 1'b0, 1'b0);
    release_bus();
    drain_responses(10);
    rdata = last_rdata;
  endtask

  // response monitor with one expected entry per request in issue order
  always @(negedge clk) begin
    if (ndmreset_n === 1'b1) begin
      if (due_q.size() > 0 && due_q[0] == cycle_cnt) begin
        assert (rsp_valid_o === 1'b1)
          else fail_now($sformatf("missing response in cycle %0d", cycle_cnt));
        check_eq("rsp_o.err", rsp_o.err, exp_err_q[0]);
        if (check_q[0]) begin
          check_eq("rsp_o.rdata", rsp_o.rdata, exp_rdata_q[0]);
        end
        last_rdata = rsp_o.rdata;
        void'(due_q.pop_front());
        void'(exp_rdata_q.pop_front());
        void'(exp_err_q.pop_front());
        void'(check_q.pop_front());
        done_cnt++;
      end else begin
        assert (rsp_valid_o === 1'b0)
          else fail_now($sformatf("response without a pending request in cycle %0d",
                                  cycle_cnt));
      end
    end
  end

  // --------------------------------------------------------------------
  // case file replay with requests back to back
  // --------------------------------------------------------------------
  task automatic run_cases();
    int                   fd;
    int                   n;
    int                   count;
    string                line;
    logic                 op;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [DataWidth-1:0] exp_rdata;
    logic                 exp_err;
    fd = $fopen("soc_cases.txt", "r");
    assert (fd != 0) else fail_now("cannot open soc_cases.txt");
    count = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.substr(0, 0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h", op, addr, wdata, exp_rdata, exp_err);
        if (n == 5) begin
          issue_req(bus_op_e'(op), addr, wdata, exp_rdata, exp_err, 1'b1);
          count++;
        end else begin
          assert (n <= 0) else fail_now($sformatf("malformed case line: %s", line));
        end
      end
    end
    $fclose(fd);
    release_bus();
    drain_responses(20);
    assert (count > 0) else fail_now("case file holds no cases");
  endtask

  // --------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------
  initial begin
    logic [DataWidth-1:0] rdata;
    logic [7:0]           sw_val;
    logic [7:0]           led_val;
    int unsigned          waited;
    int unsigned          highs;
    seed        = 32'he8cd_e58d;
    ndmreset_n  = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    sw_i        = '0;
    repeat (16) @(posedge clk);
    ndmreset_n <= 1'b1;
    // no edge has run since the release, so the outputs show their reset values
    @(negedge clk);
    check_eq("timer_irq_o", timer_irq_o, 1'b0);
    check_eq("ipi_o", ipi_o, 1'b0);
    check_eq("fan_pwm_o", fan_pwm_o, 1'b0);
    check_eq("led_o", led_o, 8'h00);

    run_cases();

    // msip drives ipi
    bus_access(OP_WRITE, ClintBase + MsipOffset, 64'd1, rdata);
    check_eq("ipi_o", ipi_o, 1'b1);
    bus_access(OP_READ, ClintBase + MsipOffset, '0, rdata);
    check_eq("msip", rdata, 64'd1);
    bus_access(OP_WRITE, ClintBase + MsipOffset, 64'd0, rdata);
    check_eq("ipi_o", ipi_o, 1'b0);
    bus_access(OP_READ, ClintBase + MsipOffset, '0, rdata);
    check_eq("msip", rdata, 64'd0);

    // timer compare
    bus_access(OP_WRITE, ClintBase + MtimeOffset, 64'd0, rdata);
    bus_access(OP_WRITE, ClintBase + MtimecmpOffset, 64'd40, rdata);
    check_eq("timer_irq_o", timer_irq_o, 1'b0);
    waited = 0;
    while (timer_irq_o !== 1'b1) begin
      @(negedge clk);
      waited++;
      assert (waited <= 200) else fail_now("timer_irq_o did not rise within 200 cycles");
    end
    bus_access(OP_READ, ClintBase + MtimeOffset, '0, rdata);
    assert (rdata >= 64'd40)
      else fail_now($sformatf("Error: mtime = 0x%h, expected at least 0x28", rdata));

    // leds and switches
    sw_val  = $random(seed);
    led_val = $random(seed);
    @(posedge clk);
    sw_i <= sw_val;
    bus_access(OP_WRITE, BoardBase + LedOffset, {56'd0, led_val}, rdata);
    check_eq("led_o", led_o, led_val);
    bus_access(OP_READ, BoardBase + LedOffset, '0, rdata);
    check_eq("led readback", rdata, {56'd0, led_val});
    bus_access(OP_READ, BoardBase + SwOffset, '0, rdata);
    check_eq("sw readback", rdata, {56'd0, sw_val});

    // fan duty over one full pwm period
    repeat (2) begin
      sw_val = $random(seed);
      @(posedge clk);
      sw_i <= sw_val;
      repeat (2) @(posedge clk);
      highs = 0;
      repeat (16) begin
        @(negedge clk);
        if (fan_pwm_o) begin
          highs++;
        end
      end
      check_eq("fan_pwm_o high cycles", highs, sw_val[3:0]);
    end

    $display("Regression passed");
    $finish;
  end

endmodule

// ==== soc_cases.txt ====
# columns: op addr wdata expected_rdata expected_err, all hex
# op 0 is a read, op 1 a write; the lines are issued on consecutive cycles
0 00010000 0000000000000000 b00700004ff8ffff 0
0 00010028 0000000000000000 b00700054ff8fffa 0
0 00010078 0000000000000000 b007000f4ff8fff0 0
1 00010028 1234567890abcdef 0000000000000000 1
0 00010028 0000000000000000 b00700054ff8fffa 0
0 00010080 0000000000000000 0000000000000000 0
0 00000000 0000000000000000 0000000000000000 1
0 00011000 0000000000000000 0000000000000000 1
0 01fffff8 0000000000000000 0000000000000000 1
0 0200c000 0000000000000000 0000000000000000 1
1 0200c000 deadbeefcafef00d 0000000000000000 1
0 40001000 0000000000000000 0000000000000000 1
0 ffffff00 0000000000000000 0000000000000000 1
0 02004000 0000000000000000 ffffffffffffffff 0
0 02000008 0000000000000000 0000000000000000 0
1 40000000 00000000000000a5 0000000000000000 0
0 40000000 0000000000000000 00000000000000a5 0
1 02000000 0000000000000001 0000000000000000 0
0 02000000 0000000000000000 0000000000000001 0
1 02000000 0000000000000000 0000000000000000 0
0 02000000 0000000000000000 0000000000000000 0

// ==== filelist.f ====
soc_pkg.sv
addr_decode.sv
boot_rom.sv
clint_timer.sv
board_ctrl.sv
resp_merge.sv
soc_top.sv
tb_soc.sv
